// File: logic/cpu_pkg.sv
package cpu_pkg;

    localparam int data_width       = 16;
    localparam int addr_width       = 6;
    localparam int field_addr_width = 3;

    typedef logic [data_width-1:0]       word_t;
    typedef logic [addr_width-1:0]       addr_t;
    typedef logic [field_addr_width-1:0] field_addr_t;

    // first instruction word is fetched from here
    localparam addr_t pc_start = 6'd8;

    typedef enum logic [3:0] {
        op_mov  = 4'd0,
        op_add  = 4'd1,
        op_sub  = 4'd2,
        op_mul  = 4'd3,
        op_div  = 4'd4,
        op_in   = 4'd7,
        op_out  = 4'd8,
        op_stop = 4'd15
    } opcode_t;

    // indirect flag sits above the 3-bit address
    typedef struct packed {
        logic        ind;
        field_addr_t addr;
    } operand_t;

    // same layout as the memory word, opcode in the top nibble
    typedef struct packed {
        opcode_t  opcode;
        operand_t x;
        operand_t y;
        operand_t z;
    } instr_t;

    typedef struct packed {
        opcode_t opcode;
        word_t   y_val;
        word_t   z_val;
        addr_t   dest;
    } exec_req_t;

    typedef struct packed {
        logic  wr_en;
        logic  out_en;
        addr_t dest;
        word_t value;
    } result_t;

    typedef enum logic [3:0] {
        st_fetch_addr,
        st_fetch_wait,
        st_fetch_load,
        st_decode,
        st_x_addr,
        st_x_wait,
        st_x_load,
        st_y_addr,
        st_y_wait,
        st_y_load,
        st_z_addr,
        st_z_wait,
        st_z_load,
        st_issue,
        st_wait_done,
        st_halt
    } decode_state_t;

endpackage

// File: logic/cpu_decode.sv
`timescale 1ns/100ps

module cpu_decode (
    input  logic               clk,
    input  logic               rst_n,
    input  cpu_pkg::word_t     mem,
    input  cpu_pkg::word_t     in,
    input  logic               done,
    output cpu_pkg::addr_t     rd_addr,
    output cpu_pkg::addr_t     pc,
    output cpu_pkg::exec_req_t exec_req,
    output logic               go
);

    cpu_pkg::decode_state_t state_q;
    cpu_pkg::instr_t        ir_q;
    cpu_pkg::addr_t         pc_q;
    cpu_pkg::addr_t         mar_q;
    // holds the pointer word while an indirect operand is followed
    cpu_pkg::word_t         data_q;
    cpu_pkg::word_t         y_q;
    cpu_pkg::word_t         z_q;
    cpu_pkg::addr_t         dest_q;
    logic                   ind_q;
    cpu_pkg::operand_t      cur_operand;

    // operand field being addressed
    always_comb begin
        case (state_q)
            cpu_pkg::st_y_addr: cur_operand = ir_q.y;
            cpu_pkg::st_z_addr: cur_operand = ir_q.z;
            default:            cur_operand = ir_q.x;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= cpu_pkg::st_fetch_addr;
            pc_q    <= cpu_pkg::pc_start;
            mar_q   <= '0;
            ind_q   <= 1'b0;
        end else begin
            case (state_q)
                cpu_pkg::st_fetch_addr: begin
                    mar_q   <= pc_q;
                    state_q <= cpu_pkg::st_fetch_wait;
                end
                cpu_pkg::st_fetch_wait: begin
                    pc_q    <= pc_q + 1'b1;
                    state_q <= cpu_pkg::st_fetch_load;
                end
                cpu_pkg::st_fetch_load: begin
                    ir_q    <= cpu_pkg::instr_t'(mem);
                    state_q <= cpu_pkg::st_decode;
                end
                cpu_pkg::st_decode: begin
                    case (ir_q.opcode)
                        cpu_pkg::op_mov, cpu_pkg::op_add, cpu_pkg::op_sub,
                        cpu_pkg::op_mul: begin
                            if (ir_q.x.ind) begin
                                state_q <= cpu_pkg::st_x_addr;
                            end else begin
                                dest_q  <= cpu_pkg::addr_t'(ir_q.x.addr);
                                state_q <= cpu_pkg::st_y_addr;
                            end
                        end
                        cpu_pkg::op_in: begin
                            if (ir_q.x.ind) begin
                                state_q <= cpu_pkg::st_x_addr;
                            end else begin
                                dest_q  <= cpu_pkg::addr_t'(ir_q.x.addr);
                                y_q     <= in;
                                state_q <= cpu_pkg::st_issue;
                            end
                        end
                        cpu_pkg::op_out: state_q <= cpu_pkg::st_x_addr;
                        // stop, div and undefined codes
                        default: state_q <= cpu_pkg::st_halt;
                    endcase
                end
                cpu_pkg::st_x_addr, cpu_pkg::st_y_addr, cpu_pkg::st_z_addr: begin
                    // second pass of an indirect read uses the pointer
                    if (ind_q) begin
                        mar_q <= data_q[cpu_pkg::addr_width-1:0];
                    end else begin
                        mar_q <= cpu_pkg::addr_t'(cur_operand.addr);
                    end
                    if (state_q == cpu_pkg::st_x_addr) begin
                        state_q <= cpu_pkg::st_x_wait;
                    end else if (state_q == cpu_pkg::st_y_addr) begin
                        state_q <= cpu_pkg::st_y_wait;
                    end else begin
                        state_q <= cpu_pkg::st_z_wait;
                    end
                end
                cpu_pkg::st_x_wait: state_q <= cpu_pkg::st_x_load;
                cpu_pkg::st_y_wait: state_q <= cpu_pkg::st_y_load;
                cpu_pkg::st_z_wait: state_q <= cpu_pkg::st_z_load;
                cpu_pkg::st_x_load: begin
                    if (ir_q.opcode != cpu_pkg::op_out) begin
                        // writing op, the word read is the destination pointer
                        dest_q <= mem[cpu_pkg::addr_width-1:0];
                        if (ir_q.opcode == cpu_pkg::op_in) begin
                            y_q     <= in;
                            state_q <= cpu_pkg::st_issue;
                        end else begin
                            state_q <= cpu_pkg::st_y_addr;
                        end
                    end else if (ir_q.x.ind && !ind_q) begin
                        data_q  <= mem;
                        ind_q   <= 1'b1;
                        state_q <= cpu_pkg::st_x_addr;
                    end else begin
                        // out value travels in the y slot
                        y_q     <= mem;
                        ind_q   <= 1'b0;
                        state_q <= cpu_pkg::st_issue;
                    end
                end
                cpu_pkg::st_y_load: begin
                    if (ir_q.y.ind && !ind_q) begin
                        data_q  <= mem;
                        ind_q   <= 1'b1;
                        state_q <= cpu_pkg::st_y_addr;
                    end else begin
                        y_q   <= mem;
                        ind_q <= 1'b0;
                        if (ir_q.opcode == cpu_pkg::op_mov) begin
                            state_q <= cpu_pkg::st_issue;
                        end else begin
                            state_q <= cpu_pkg::st_z_addr;
                        end
                    end
                end
                cpu_pkg::st_z_load: begin
                    if (ir_q.z.ind && !ind_q) begin
                        data_q  <= mem;
                        ind_q   <= 1'b1;
                        state_q <= cpu_pkg::st_z_addr;
                    end else begin
                        z_q     <= mem;
                        ind_q   <= 1'b0;
                        state_q <= cpu_pkg::st_issue;
                    end
                end
                cpu_pkg::st_issue: state_q <= cpu_pkg::st_wait_done;
                cpu_pkg::st_wait_done: begin
                    if (done) begin
                        state_q <= cpu_pkg::st_fetch_addr;
                    end
                end
                // only reset leaves halt
                default: state_q <= cpu_pkg::st_halt;
            endcase
        end
    end

    assign rd_addr = mar_q;
    assign pc      = pc_q;
    assign go      = (state_q == cpu_pkg::st_issue);

    assign exec_req = '{
        opcode: ir_q.opcode,
        y_val:  y_q,
        z_val:  z_q,
        dest:   dest_q
    };

endmodule

// File: logic/cpu_execute.sv
`timescale 1ns/100ps

module cpu_execute (
    input  logic               clk,
    input  logic               rst_n,
    input  cpu_pkg::exec_req_t exec_req,
    input  logic               go,
    output cpu_pkg::result_t   res,
    output logic               res_valid
);

    cpu_pkg::result_t res_d;
    cpu_pkg::result_t res_q;
    logic             res_valid_q;

    always_comb begin
        res_d.wr_en  = 1'b1;
        res_d.out_en = 1'b0;
        res_d.dest   = exec_req.dest;
        // mov and in pass y straight through
        res_d.value  = exec_req.y_val;
        case (exec_req.opcode)
            cpu_pkg::op_add: res_d.value = exec_req.y_val + exec_req.z_val;
            cpu_pkg::op_sub: res_d.value = exec_req.y_val - exec_req.z_val;
            // low half of the product only
            cpu_pkg::op_mul: res_d.value = exec_req.y_val * exec_req.z_val;
            cpu_pkg::op_out: begin
                res_d.wr_en  = 1'b0;
                res_d.out_en = 1'b1;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_valid_q <= 1'b0;
        end else begin
            res_valid_q <= go;
        end
    end

    always_ff @(posedge clk) begin
        if (go) begin
            res_q <= res_d;
        end
    end

    assign res       = res_q;
    assign res_valid = res_valid_q;

endmodule

// File: logic/cpu_result.sv
`timescale 1ns/100ps

module cpu_result (
    input  logic             clk,
    input  logic             rst_n,
    input  cpu_pkg::result_t res,
    input  logic             res_valid,
    input  cpu_pkg::addr_t   rd_addr,
    output logic             we,
    output cpu_pkg::addr_t   addr,
    output cpu_pkg::word_t   data,
    output cpu_pkg::word_t   out,
    output logic             done
);

    logic           we_q;
    logic           done_q;
    cpu_pkg::addr_t wr_addr_q;
    cpu_pkg::word_t wr_data_q;
    cpu_pkg::word_t out_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            we_q   <= 1'b0;
            done_q <= 1'b0;
            out_q  <= '0;
        end else begin
            we_q   <= res_valid && res.wr_en;
            done_q <= res_valid;
            if (res_valid && res.out_en) begin
                out_q <= res.value;
            end
        end
    end

    // write payload
    always_ff @(posedge clk) begin
        if (res_valid && res.wr_en) begin
            wr_addr_q <= res.dest;
            wr_data_q <= res.value;
        end
    end

    // bus belongs to decode's reads except in the write cycle
    assign addr = we_q ? wr_addr_q : rd_addr;
    assign we   = we_q;
    assign data = wr_data_q;
    assign out  = out_q;
    assign done = done_q;

endmodule

// File: logic/cpu_top.sv
`timescale 1ns/100ps

module cpu_top (
    input  logic           clk,
    input  logic           rst_n,
    input  cpu_pkg::word_t mem,
    input  cpu_pkg::word_t in,
    output logic           we,
    output cpu_pkg::addr_t addr,
    output cpu_pkg::word_t data,
    output cpu_pkg::word_t out,
    output cpu_pkg::addr_t pc
);

    cpu_pkg::addr_t     rd_addr;
    cpu_pkg::exec_req_t exec_req;
    logic               go;
    cpu_pkg::result_t   res;
    logic               res_valid;
    logic               done;

    cpu_decode u_decode (
        .clk      (clk),
        .rst_n    (rst_n),
        .mem      (mem),
        .in       (in),
        .done     (done),
        .rd_addr  (rd_addr),
        .pc       (pc),
        .exec_req (exec_req),
        .go       (go)
    );

    cpu_execute u_execute (
        .clk       (clk),
        .rst_n     (rst_n),
        .exec_req  (exec_req),
        .go        (go),
        .res       (res),
        .res_valid (res_valid)
    );

    cpu_result u_result (
        .clk       (clk),
        .rst_n     (rst_n),
        .res       (res),
        .res_valid (res_valid),
        .rd_addr   (rd_addr),
        .we        (we),
        .addr      (addr),
        .data      (data),
        .out       (out),
        .done      (done)
    );

endmodule

// File: dv/tb_cpu_programs.svh
// program image, in port value and the predicted bus activity of one test
cpu_pkg::word_t in_val;
cpu_pkg::word_t ref_mem [64];
cpu_pkg::addr_t exp_wr_addr [$];
cpu_pkg::word_t exp_wr_data [$];
cpu_pkg::word_t exp_out [$];
cpu_pkg::addr_t halt_pc;

function automatic logic [3:0] direct_operand(input cpu_pkg::field_addr_t a);
    return {1'b0, a};
endfunction

function automatic logic [3:0] indirect_operand(input cpu_pkg::field_addr_t a);
    return {1'b1, a};
endfunction

function automatic cpu_pkg::word_t make_instr(input cpu_pkg::opcode_t op,
        input logic [3:0] x, input logic [3:0] y, input logic [3:0] z);
    return {op, x, y, z};
endfunction

// pointer word keeps its target in the low 6 bits
function automatic cpu_pkg::addr_t operand_addr(input logic [3:0] field);
    if (field[3]) begin
        return ref_mem[field[2:0]][5:0];
    end
    return {3'b000, field[2:0]};
endfunction

// walks the image and records every write and out value until a halt
task automatic predict_program();
    cpu_pkg::word_t w;
    cpu_pkg::word_t y_val;
    cpu_pkg::word_t z_val;
    cpu_pkg::word_t value;
    cpu_pkg::addr_t dest;
    cpu_pkg::addr_t pc_r;
    logic [3:0]     op;
    logic           running;
    exp_wr_addr.delete();
    exp_wr_data.delete();
    exp_out.delete();
    for (int i = 0; i < 64; i++) begin
        ref_mem[i] = image[i];
    end
    pc_r    = cpu_pkg::pc_start;
    running = 1'b1;
    while (running) begin
        w     = ref_mem[pc_r];
        pc_r  = pc_r + 6'd1;
        op    = w[15:12];
        dest  = operand_addr(w[11:8]);
        y_val = ref_mem[operand_addr(w[7:4])];
        z_val = ref_mem[operand_addr(w[3:0])];
        case (op)
            cpu_pkg::op_add: value = y_val + z_val;
            cpu_pkg::op_sub: value = y_val - z_val;
            cpu_pkg::op_mul: value = y_val * z_val;
            cpu_pkg::op_in:  value = in_val;
            default:         value = y_val;
        endcase
        case (op)
            cpu_pkg::op_mov, cpu_pkg::op_add, cpu_pkg::op_sub, cpu_pkg::op_mul,
            cpu_pkg::op_in: begin
                ref_mem[dest] = value;
                exp_wr_addr.push_back(dest);
                exp_wr_data.push_back(value);
            end
            cpu_pkg::op_out: exp_out.push_back(ref_mem[dest]);
            // stop, div and anything undefined
            default: running = 1'b0;
        endcase
    end
    halt_pc = pc_r;
endtask

task automatic build_program(input int kind);
    for (int i = 0; i < 64; i++) begin
        image[i] = cpu_pkg::word_t'($urandom);
    end
    in_val = cpu_pkg::word_t'($urandom);
    case (kind)
        0: begin
            test_name = "in_out";
            image[8]  = make_instr(cpu_pkg::op_in, direct_operand(3'd2), 4'h0, 4'h0);
            image[9]  = make_instr(cpu_pkg::op_out, direct_operand(3'd2), 4'h0, 4'h0);
            image[10] = make_instr(cpu_pkg::op_stop, 4'h0, 4'h0, 4'h0);
        end
        1: begin
            test_name = "arith_direct";
            image[8]  = make_instr(cpu_pkg::op_add, direct_operand(3'd3),
                                   direct_operand(3'd0), direct_operand(3'd1));
            image[9]  = make_instr(cpu_pkg::op_sub, direct_operand(3'd4),
                                   direct_operand(3'd0), direct_operand(3'd1));
            image[10] = make_instr(cpu_pkg::op_mul, direct_operand(3'd5),
                                   direct_operand(3'd0), direct_operand(3'd1));
            image[11] = make_instr(cpu_pkg::op_mov, direct_operand(3'd6),
                                   direct_operand(3'd5), 4'h0);
            image[12] = make_instr(cpu_pkg::op_add, direct_operand(3'd7),
                                   direct_operand(3'd7), direct_operand(3'd6));
            image[13] = make_instr(cpu_pkg::op_out, direct_operand(3'd7), 4'h0, 4'h0);
            image[14] = make_instr(cpu_pkg::op_stop, 4'h0, 4'h0, 4'h0);
        end
        2: begin
            test_name = "indirect";
            // random upper bits in the pointer words
            image[0][5:0] = 6'd40;
            image[1][5:0] = 6'd41;
            image[2][5:0] = 6'd42;
            image[3][5:0] = 6'd43;
            image[8]  = make_instr(cpu_pkg::op_add, indirect_operand(3'd2),
                                   indirect_operand(3'd0), indirect_operand(3'd1));
            image[9]  = make_instr(cpu_pkg::op_mul, indirect_operand(3'd3),
                                   indirect_operand(3'd2), direct_operand(3'd4));
            image[10] = make_instr(cpu_pkg::op_sub, direct_operand(3'd5),
                                   indirect_operand(3'd3), indirect_operand(3'd0));
            image[11] = make_instr(cpu_pkg::op_in, indirect_operand(3'd2), 4'h0, 4'h0);
            image[12] = make_instr(cpu_pkg::op_out, indirect_operand(3'd3), 4'h0, 4'h0);
            image[13] = make_instr(cpu_pkg::op_mov, indirect_operand(3'd3),
                                   indirect_operand(3'd2), 4'h0);
            image[14] = make_instr(cpu_pkg::op_stop, 4'h0, 4'h0, 4'h0);
        end
        3: begin
            test_name = "stop";
            image[8]  = make_instr(cpu_pkg::op_mov, direct_operand(3'd1),
                                   direct_operand(3'd0), 4'h0);
            image[9]  = make_instr(cpu_pkg::op_out, direct_operand(3'd1), 4'h0, 4'h0);
            image[10] = make_instr(cpu_pkg::op_stop, 4'h0, 4'h0, 4'h0);
            // never reached
            image[11] = make_instr(cpu_pkg::op_add, direct_operand(3'd2),
                                   direct_operand(3'd0), direct_operand(3'd0));
            image[12] = make_instr(cpu_pkg::op_mov, direct_operand(3'd3),
                                   direct_operand(3'd0), 4'h0);
        end
        default: begin
            test_name = "div_halt";
            image[8]  = make_instr(cpu_pkg::op_mov, direct_operand(3'd1),
                                   direct_operand(3'd0), 4'h0);
            image[9]  = make_instr(cpu_pkg::op_div, direct_operand(3'd2),
                                   direct_operand(3'd0), direct_operand(3'd1));
            image[10] = make_instr(cpu_pkg::op_add, direct_operand(3'd3),
                                   direct_operand(3'd0), direct_operand(3'd1));
            image[11] = make_instr(cpu_pkg::op_out, direct_operand(3'd0), 4'h0, 4'h0);
        end
    endcase
endtask

// File: dv/tb_cpu.sv
`timescale 1ns/100ps

module tb_cpu;

    localparam int num_programs = 5;
    localparam int idle_cycles  = 100;

    logic           clk;
    logic           rst_n;
    cpu_pkg::word_t mem = '0;
    cpu_pkg::word_t in;
    logic           we;
    cpu_pkg::addr_t addr;
    cpu_pkg::word_t data;
    cpu_pkg::word_t out;
    cpu_pkg::addr_t pc;

    cpu_pkg::word_t ram   [64];
    cpu_pkg::word_t image [64];
    logic           load_image;

    int    errors;
    int    tests_ok;
    int    tests_bad;
    string test_name;

    `include "tb_cpu_programs.svh"

    cpu_top uut (
        .clk   (clk),
        .rst_n (rst_n),
        .mem   (mem),
        .in    (in),
        .we    (we),
        .addr  (addr),
        .data  (data),
        .out   (out),
        .pc    (pc)
    );

    always #5 clk = ~clk;

    // memory model with a registered read one cycle after addr
    always @(posedge clk) begin
        if (load_image) begin
            for (int i = 0; i < 64; i++) begin
                ram[i] <= image[i];
            end
        end else if (we) begin
            ram[addr] <= data;
        end
        mem <= ram[addr];
    end

    function automatic void check_value(input string what, input logic [15:0] expected,
            input logic [15:0] actual);
        assert (actual === expected) else begin
            $display("MISMATCH %s %s: expected %h actual %h", test_name, what, expected,
                     actual);
            errors++;
        end
    endfunction

    function automatic void check_true(input logic cond, input string what);
        assert (cond) else begin
            $display("ERROR %s: %s", test_name, what);
            errors++;
        end
    endfunction

    task automatic check_reset_state();
        check_value("reset we", 16'h0, 16'(we));
        check_value("reset out", 16'h0, out);
        check_value("reset pc", 16'(cpu_pkg::pc_start), 16'(pc));
    endtask

    task automatic run_program(input int kind);
        int             start_errors;
        cpu_pkg::word_t last_out;
        start_errors = errors;
        build_program(kind);
        predict_program();
        @(posedge clk);
        rst_n      <= 1'b0;
        in         <= in_val;
        load_image <= 1'b1;
        repeat (10) begin
            @(negedge clk);
            check_reset_state();
            @(posedge clk);
            load_image <= 1'b0;
        end
        rst_n <= 1'b1;
        @(negedge clk);
        check_reset_state();
        last_out = out;
        // follow writes and out changes until the CPU has fetched its halting word
        while (exp_wr_addr.size() != 0 || exp_out.size() != 0 || pc != halt_pc) begin
            @(negedge clk);
            if (we) begin
                check_true(exp_wr_addr.size() != 0, "a write appeared that was not expected");
                if (exp_wr_addr.size() != 0) begin
                    check_value("write addr", 16'(exp_wr_addr.pop_front()), 16'(addr));
                    check_value("write data", exp_wr_data.pop_front(), data);
                end
            end
            if (out != last_out) begin
                check_true(exp_out.size() != 0, "out changed without an out instruction");
                if (exp_out.size() != 0) begin
                    check_value("out", exp_out.pop_front(), out);
                end
                last_out = out;
            end
        end
        // after the halt pc and the bus stay still
        repeat (idle_cycles) begin
            @(negedge clk);
            check_true(!we, "a write appeared after the CPU halted");
            check_value("halted pc", 16'(halt_pc), 16'(pc));
        end
        if (errors == start_errors) begin
            tests_ok++;
            $display("test %s: ok", test_name);
        end else begin
            tests_bad++;
            $display("test %s: %0d errors", test_name, errors - start_errors);
        end
    endtask

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        in         = '0;
        load_image = 1'b0;
        errors     = 0;
        tests_ok   = 0;
        tests_bad  = 0;
        void'($urandom(32'hfb77));
        for (int k = 0; k < num_programs; k++) begin
            run_program(k);
        end
        $display("summary: %0d tests ok, %0d tests with errors, %0d errors", tests_ok,
                 tests_bad, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // watchdog sized for 40 instructions of 12 cycles per program
    initial begin
        #(num_programs * 40 * 12 * 10);
        $display("timeout: the programs did not finish in the allowed time");
        $display("Testbench failed");
        $finish;
    end

endmodule

// File: build.f
+incdir+dv
logic/cpu_pkg.sv
logic/cpu_decode.sv
logic/cpu_execute.sv
logic/cpu_result.sv
logic/cpu_top.sv
dv/tb_cpu.sv

// File: Makefile
# Verilator build for the multicycle CPU testbench

VERILATOR ?= verilator
TOP       ?= tb_cpu
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_MSG  ?= Testbench passed

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@sim_out="$$(./$(SIM_BIN))"; \
	echo "$$sim_out"; \
	echo "$$sim_out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
